// ==== hw/uba_settings.svh ====
/*
   Build settings for the Unibus adapter.
   UBA_TIMEOUT must stay within 2..15 to fit the 4-bit timeout counter.
*/
`ifndef UBA_SETTINGS_SVH
`define UBA_SETTINGS_SVH

// Device number and status register address
`define UBA_DEVICE      4'd3
`define UBA_STATUS_ADDR 18'o763100
// Unibus cycles allowed before a forced end
`define UBA_TIMEOUT     12

// Word widths
`define UBA_WORD        36
`define UBA_UNI_ADDR    18
`define UBA_UNI_DATA    16

// CPU address word layout
`define UBA_RDFLAG      35
`define UBA_WRFLAG      34
`define UBA_IOFLAG      33
`define UBA_DEV_HI      21
`define UBA_DEV_LO      18
`define UBA_ADDR_HI     17
`define UBA_ADDR_LO     0

`endif

// ==== hw/ubaPkg.sv ====
/*
   Shared types for the Unibus adapter.
   The data word is read as a status layout or as a Unibus layout.
   Bit 35 of the status view is internal and never reaches busDATAO.
*/
`include "uba_settings.svh"

package ubaPkg;

   ////////////////////
   // Decoded command
   ////////////////////
   typedef enum logic [2:0]
   {
      cmdNone,
      cmdStatRd,
      cmdStatWr,
      cmdUniRd,
      cmdUniWr
   } ubaCmd_t;

   ////////////////////
   // Data word views
   ////////////////////

   // Status register layout
   typedef struct packed
   {
      // Execute marks a local status read here
      logic        statSel;
      logic [16:0] rsvdHi;
      // Timeout, write one to clear
      logic        tmo;
      logic [9:0]  rsvdMid;
      logic        intEnable;
      logic [5:0]  rsvdLo;
   } ubaStat_t;

   // Unibus data layout, 16 bits in the low end
   typedef struct packed
   {
      logic [`UBA_WORD-`UBA_UNI_DATA-1:0] rsvd;
      logic [`UBA_UNI_DATA-1:0]           data;
   } ubaUni_t;

   typedef union packed
   {
      ubaStat_t stat;
      ubaUni_t  uni;
   } ubaWord_t;

endpackage

// ==== hw/ubaTimeout.sv ====
/*
   Unibus acknowledge monitor.
   Loads UBA_TIMEOUT on start; expired is high while the count is one.
   An ack in the same cycle as start is not seen.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaTimeout
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic ack,
   output logic expired
);

   logic [3:0] count;

   ////////////////////
   // Down-counter
   ////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         count <= '0;
      else if (start)
         count <= 4'(`UBA_TIMEOUT);
      // Acked transfer, monitor goes idle
      else if (ack)
         count <= '0;
      else if (count != '0)
         count <= count - 4'd1;
   end

   // Last cycle of the allowed window
   assign expired = (count == 4'd1);

endmodule

// ==== hw/ubaDecode.sv ====
/*
   CPU request decode.
   One request at a time; requests while busy are dropped.
   Both or neither direction flag set means the request is ignored.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaDecode
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      busREQI,
   input  logic [`UBA_WORD-1:0]      busADDRI,
   input  logic [`UBA_WORD-1:0]      busDATAI,
   input  logic                      busy,
   output ubaPkg::ubaCmd_t           cmd,
   output logic [`UBA_UNI_ADDR-1:0]  cmdAddr,
   output ubaPkg::ubaWord_t          cmdData
);

   logic                     rdFlag;
   logic                     wrFlag;
   logic                     ioFlag;
   logic                     devHit;
   logic                     statHit;
   logic                     accept;
   logic [`UBA_UNI_ADDR-1:0] ioAddr;
   ubaPkg::ubaCmd_t          nextCmd;

   ////////////////////
   // Address fields
   ////////////////////
   assign rdFlag  = busADDRI[`UBA_RDFLAG];
   assign wrFlag  = busADDRI[`UBA_WRFLAG];
   assign ioFlag  = busADDRI[`UBA_IOFLAG];
   assign ioAddr  = busADDRI[`UBA_ADDR_HI:`UBA_ADDR_LO];
   assign devHit  = (busADDRI[`UBA_DEV_HI:`UBA_DEV_LO] == `UBA_DEVICE);
   assign statHit = (ioAddr == `UBA_STATUS_ADDR);

   // I/O request for this device, exactly one direction
   assign accept = busREQI & ~busy & ioFlag & devHit & (rdFlag ^ wrFlag);

   ////////////////////
   // Classification
   ////////////////////
   always_comb
   begin
      nextCmd = ubaPkg::cmdNone;
      if (accept)
      begin
         if (statHit)
            nextCmd = rdFlag ? ubaPkg::cmdStatRd : ubaPkg::cmdStatWr;
         else
            nextCmd = rdFlag ? ubaPkg::cmdUniRd : ubaPkg::cmdUniWr;
      end
   end

   // Command pulse, one cycle after the strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cmd <= ubaPkg::cmdNone;
      else
         cmd <= nextCmd;
   end

   // Address and data ride along with the command
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cmdAddr <= ioAddr;
         cmdData <= busDATAI;
      end
   end

endmodule

// ==== hw/ubaExecute.sv ====
/*
   Command execution: status register and Unibus transfers.
   One Unibus transfer is open at a time; busy covers it.
   Status reads return only a marker, result fills in the live bits.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaExecute
(
   input  logic                      clk,
   input  logic                      rst,
   input  ubaPkg::ubaCmd_t           cmd,
   input  logic [`UBA_UNI_ADDR-1:0]  cmdAddr,
   input  ubaPkg::ubaWord_t          cmdData,
   input  logic                      uniACKI,
   input  logic [`UBA_UNI_DATA-1:0]  uniDATAI,
   output logic                      uniREQO,
   output logic                      uniWRO,
   output logic [`UBA_UNI_ADDR-1:0]  uniADDRO,
   output logic [`UBA_UNI_DATA-1:0]  uniDATAO,
   output logic                      busy,
   output logic                      done,
   output logic [`UBA_WORD-1:0]      doneData,
   output logic                      tmo,
   output logic                      intEnable
);

   logic             uniCmd;
   logic             statCmd;
   logic             uniAck;
   logic             expired;
   logic             uniEnd;
   ubaPkg::ubaWord_t result;

   assign uniCmd  = (cmd == ubaPkg::cmdUniRd) | (cmd == ubaPkg::cmdUniWr);
   assign statCmd = (cmd == ubaPkg::cmdStatRd) | (cmd == ubaPkg::cmdStatWr);
   // Only acks for an open transfer count
   assign uniAck  = uniREQO & uniACKI;
   // Ack or timeout closes the transfer
   assign uniEnd  = uniAck | (uniREQO & expired);
   assign busy    = uniREQO;

   ubaTimeout u_timeout
   (
      .clk     (clk),
      .rst     (rst),
      .start   (uniCmd),
      .ack     (uniAck),
      .expired (expired)
   );

   ////////////////////
   // Unibus request
   ////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         uniREQO <= 1'b0;
         uniWRO  <= 1'b0;
      end
      else if (uniCmd)
      begin
         uniREQO <= 1'b1;
         uniWRO  <= (cmd == ubaPkg::cmdUniWr);
      end
      else if (uniEnd)
         uniREQO <= 1'b0;
   end

   // Held stable for the whole transfer
   always_ff @(posedge clk)
   begin
      if (uniCmd)
      begin
         uniADDRO <= cmdAddr;
         uniDATAO <= cmdData.uni.data;
      end
   end

   ////////////////////
   // Status register
   ////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         tmo       <= 1'b0;
         intEnable <= 1'b0;
      end
      // Missing ack, ack in the last cycle still wins
      else if (uniREQO & expired & ~uniACKI)
         tmo <= 1'b1;
      else if (cmd == ubaPkg::cmdStatWr)
      begin
         tmo       <= tmo & ~cmdData.stat.tmo;
         intEnable <= cmdData.stat.intEnable;
      end
   end

   ////////////////////
   // Completion
   ////////////////////
   assign done = statCmd | uniEnd;

   always_comb
   begin
      result = '0;
      if (cmd == ubaPkg::cmdStatRd)
         result.stat.statSel = 1'b1;
      // Read data zero-extended, timeouts stay zero
      else if (uniAck & ~uniWRO)
         result.uni.data = uniDATAI;
      doneData = result;
   end

endmodule

// ==== hw/ubaResult.sv ====
/*
   CPU acknowledge and read data.
   busDATAO is zero outside the busACKO cycle.
   Status reads show the register as it stands in the ack cycle.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaResult
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 done,
   input  logic [`UBA_WORD-1:0] doneData,
   input  logic                 tmo,
   input  logic                 intEnable,
   output logic                 busACKO,
   output logic [`UBA_WORD-1:0] busDATAO,
   output logic                 intrO
);

   ubaPkg::ubaWord_t dataReg;
   ubaPkg::ubaWord_t ackWord;

   ////////////////////
   // Ack and interrupt
   ////////////////////
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busACKO <= 1'b0;
         intrO   <= 1'b0;
      end
      else
      begin
         busACKO <= done;
         intrO   <= tmo & intEnable;
      end
   end

   // Read word lines up with busACKO
   always_ff @(posedge clk)
   begin
      if (done)
         dataReg <= doneData;
   end

   ////////////////////
   // Data out
   ////////////////////
   always_comb
   begin
      ackWord = dataReg;
      // Local status read, swap the marker for live bits
      if (dataReg.stat.statSel)
      begin
         ackWord.stat.statSel   = 1'b0;
         ackWord.stat.tmo       = tmo;
         ackWord.stat.intEnable = intEnable;
      end
      busDATAO = busACKO ? ackWord : '0;
   end

endmodule

// ==== hw/uba.sv ====
/*
   Unibus adapter top: decode, execute, result.
   Memory requests and other device numbers get no acknowledge.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module uba
(
   input  logic                      clk,
   input  logic                      rst,
   // CPU bus
   input  logic                      busREQI,
   input  logic [`UBA_WORD-1:0]      busADDRI,
   input  logic [`UBA_WORD-1:0]      busDATAI,
   output logic                      busACKO,
   output logic [`UBA_WORD-1:0]      busDATAO,
   // Unibus
   output logic                      uniREQO,
   output logic                      uniWRO,
   output logic [`UBA_UNI_ADDR-1:0]  uniADDRO,
   output logic [`UBA_UNI_DATA-1:0]  uniDATAO,
   input  logic                      uniACKI,
   input  logic [`UBA_UNI_DATA-1:0]  uniDATAI,
   // Interrupt
   output logic                      intrO
);

   ubaPkg::ubaCmd_t          cmd;
   logic [`UBA_UNI_ADDR-1:0] cmdAddr;
   ubaPkg::ubaWord_t         cmdData;
   logic                     busy;
   logic                     done;
   logic [`UBA_WORD-1:0]     doneData;
   logic                     tmo;
   logic                     intEnable;

   ubaDecode u_decode
   (
      .clk      (clk),
      .rst      (rst),
      .busREQI  (busREQI),
      .busADDRI (busADDRI),
      .busDATAI (busDATAI),
      .busy     (busy),
      .cmd      (cmd),
      .cmdAddr  (cmdAddr),
      .cmdData  (cmdData)
   );

   ubaExecute u_execute
   (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd),
      .cmdAddr   (cmdAddr),
      .cmdData   (cmdData),
      .uniACKI   (uniACKI),
      .uniDATAI  (uniDATAI),
      .uniREQO   (uniREQO),
      .uniWRO    (uniWRO),
      .uniADDRO  (uniADDRO),
      .uniDATAO  (uniDATAO),
      .busy      (busy),
      .done      (done),
      .doneData  (doneData),
      .tmo       (tmo),
      .intEnable (intEnable)
   );

   ubaResult u_result
   (
      .clk       (clk),
      .rst       (rst),
      .done      (done),
      .doneData  (doneData),
      .tmo       (tmo),
      .intEnable (intEnable),
      .busACKO   (busACKO),
      .busDATAO  (busDATAO),
      .intrO     (intrO)
   );

endmodule

// ==== sim/uba_assert.sv ====
/*
   Concurrent protocol checks on the CPU and Unibus sides of uba.
   failCount holds the number of failed assertions so far.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaAssert
(
   input logic                     clk,
   input logic                     rst,
   input logic                     busACKO,
   input logic                     uniREQO,
   input logic                     uniWRO,
   input logic [`UBA_UNI_ADDR-1:0] uniADDRO,
   input logic [`UBA_UNI_DATA-1:0] uniDATAO,
   input logic                     intrO
);

   int failCount = 0;

   // Ack is a single-cycle pulse
   ackPulse: assert property (@(posedge clk) disable iff (rst) busACKO |=> !busACKO)
   else
   begin
      failCount++;
      $error("busACKO high for more than one cycle");
   end

   // Timeout bounds every Unibus request
   reqLength: assert property (@(posedge clk) disable iff (rst)
      $rose(uniREQO) |-> ##[1:`UBA_TIMEOUT] !uniREQO)
   else
   begin
      failCount++;
      $error("uniREQO high for more than UBA_TIMEOUT cycles");
   end

   reqStable: assert property (@(posedge clk) disable iff (rst)
      uniREQO && $past(uniREQO) |-> $stable({uniWRO, uniADDRO, uniDATAO}))
   else
   begin
      failCount++;
      $error("Unibus outputs changed while uniREQO was high");
   end

   ////////////////////
   // Reset state
   ////////////////////
   resetQuiet: assert property (@(posedge clk)
      rst |-> !busACKO && !uniREQO && !uniWRO && !intrO)
   else
   begin
      failCount++;
      $error("Control output high during reset");
   end

endmodule

bind uba ubaAssert u_ubaAssert
(
   .clk      (clk),
   .rst      (rst),
   .busACKO  (busACKO),
   .uniREQO  (uniREQO),
   .uniWRO   (uniWRO),
   .uniADDRO (uniADDRO),
   .uniDATAO (uniDATAO),
   .intrO    (intrO)
);

// ==== sim/ubaTb.sv ====
/*
   Testbench for uba with a Unibus responder model.
   Responder ack delays stay below UBA_TIMEOUT-1 so acked transfers never time out.
   Status bit positions follow the status view of the data word.
   Each Unibus transfer sees a second strobe while open, which must be ignored.
*/
`timescale 1ns/1ps
`include "uba_settings.svh"

module ubaTb;

   // Longest responder delay, at most UBA_TIMEOUT-2
   localparam int MAX_DELAY   = 8;
   localparam int NUM_XFERS   = 20;
   localparam int CYCLE_LIMIT = NUM_XFERS * (`UBA_TIMEOUT + MAX_DELAY + 4) + 200;
   localparam int TMO_BIT     = 17;
   localparam int IE_BIT      = 6;

   logic                     clk;
   logic                     rst;
   logic                     busREQI;
   logic [`UBA_WORD-1:0]     busADDRI;
   logic [`UBA_WORD-1:0]     busDATAI;
   logic                     busACKO;
   logic [`UBA_WORD-1:0]     busDATAO;
   logic                     uniREQO;
   logic                     uniWRO;
   logic [`UBA_UNI_ADDR-1:0] uniADDRO;
   logic [`UBA_UNI_DATA-1:0] uniDATAO;
   logic                     uniACKI;
   logic [`UBA_UNI_DATA-1:0] uniDATAI;
   logic                     intrO;

   // Responder setup written by the main thread between transfers
   logic                     ackEnable;
   int                       ackDelay;
   logic [`UBA_UNI_DATA-1:0] respData;

   // What waitAck saw during the last request
   int                       ackLatency;
   int                       reqCycles;
   logic [`UBA_WORD-1:0]     ackData;
   logic [`UBA_UNI_ADDR-1:0] reqAddr;
   logic [`UBA_UNI_DATA-1:0] reqData;
   logic                     reqWr;
   logic                     uniAckBefore;
   int                       cycleCount = 0;

   uba u_uba
   (
      .clk      (clk),
      .rst      (rst),
      .busREQI  (busREQI),
      .busADDRI (busADDRI),
      .busDATAI (busDATAI),
      .busACKO  (busACKO),
      .busDATAO (busDATAO),
      .uniREQO  (uniREQO),
      .uniWRO   (uniWRO),
      .uniADDRO (uniADDRO),
      .uniDATAO (uniDATAO),
      .uniACKI  (uniACKI),
      .uniDATAI (uniDATAI),
      .intrO    (intrO)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////
   task automatic stopRun(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic checkValue(input string testName, input logic [`UBA_WORD-1:0] expected,
                             input logic [`UBA_WORD-1:0] actual);
      assert (actual === expected)
      else
         stopRun($sformatf("ERROR %s: expected %h, actual %h", testName, expected, actual));
   endtask

   function automatic logic [`UBA_WORD-1:0] addrWord(input logic rd, input logic wr,
                                                     input logic io, input logic [3:0] dev,
                                                     input logic [`UBA_UNI_ADDR-1:0] addr);
      logic [`UBA_WORD-1:0] w;
      w = '0;
      w[`UBA_RDFLAG] = rd;
      w[`UBA_WRFLAG] = wr;
      w[`UBA_IOFLAG] = io;
      w[`UBA_DEV_HI:`UBA_DEV_LO] = dev;
      w[`UBA_ADDR_HI:`UBA_ADDR_LO] = addr;
      return w;
   endfunction

   // Status register image as the CPU sees it
   function automatic logic [`UBA_WORD-1:0] statusWord(input logic tmo, input logic ie);
      logic [`UBA_WORD-1:0] w;
      w = '0;
      w[TMO_BIT] = tmo;
      w[IE_BIT]  = ie;
      return w;
   endfunction

   // One-cycle strobe that returns on the edge after it
   task automatic issueRequest(input logic [`UBA_WORD-1:0] addr,
                               input logic [`UBA_WORD-1:0] data);
      @(posedge clk);
      busREQI  <= 1'b1;
      busADDRI <= addr;
      busDATAI <= data;
      @(posedge clk);
      busREQI  <= 1'b0;
   endtask

   // Samples on falling edges until busACKO
   task automatic waitAck();
      logic prevUniAck;
      prevUniAck = 1'b0;
      ackLatency = 1;
      reqCycles  = 0;
      @(negedge clk);
      while (busACKO !== 1'b1)
      begin
         if (uniREQO === 1'b1)
         begin
            if (reqCycles == 0)
            begin
               reqAddr = uniADDRO;
               reqData = uniDATAO;
               reqWr   = uniWRO;
            end
            reqCycles++;
         end
         prevUniAck = uniACKI;
         @(posedge clk);
         ackLatency++;
         @(negedge clk);
      end
      uniAckBefore = prevUniAck;
      ackData      = busDATAO;
   endtask

   task automatic statusAccess(input string testName, input logic isWrite,
                               input logic [`UBA_WORD-1:0] data,
                               input logic [`UBA_WORD-1:0] expected);
      issueRequest(addrWord(~isWrite, isWrite, 1'b1, `UBA_DEVICE, `UBA_STATUS_ADDR), data);
      waitAck();
      checkValue({testName, " ack latency"}, 2, ackLatency);
      if (!isWrite)
         checkValue({testName, " busDATAO"}, expected, ackData);
   endtask

   task automatic uniTransfer(input string testName, input logic isWrite, input int delay);
      logic [`UBA_UNI_ADDR-1:0] addr;
      logic [`UBA_WORD-1:0]     data;
      addr = 18'($urandom);
      if (addr == `UBA_STATUS_ADDR)
         addr = addr ^ 18'd1;
      data      = {4'($urandom), 32'($urandom)};
      respData  = 16'($urandom);
      ackDelay  = delay;
      ackEnable = 1'b1;
      issueRequest(addrWord(~isWrite, isWrite, 1'b1, `UBA_DEVICE, addr), data);
      // Strobe lands in the first cycle of uniREQO
      fork
         issueRequest(addrWord(~isWrite, isWrite, 1'b1, `UBA_DEVICE, addr ^ 18'o7), ~data);
         waitAck();
      join
      checkValue({testName, " uniADDRO"}, addr, reqAddr);
      checkValue({testName, " uniWRO"}, isWrite, reqWr);
      if (isWrite)
      begin
         checkValue({testName, " uniDATAO"}, data[15:0], reqData);
         checkValue({testName, " busDATAO"}, '0, ackData);
      end
      else
         checkValue({testName, " busDATAO"}, {20'b0, respData}, ackData);
      // busACKO one cycle behind uniACKI
      checkValue({testName, " uniACKI before busACKO"}, 1, uniAckBefore);
      checkValue({testName, " ack latency"}, delay + 4, ackLatency);
      checkValue({testName, " uniREQO length"}, delay + 2, reqCycles);
   endtask

   // No ack and no Unibus start for a while
   task automatic watchIdle(input string testName);
      repeat (2 * `UBA_TIMEOUT)
      begin
         @(negedge clk);
         checkValue({testName, " busACKO"}, '0, busACKO);
         checkValue({testName, " uniREQO"}, '0, uniREQO);
      end
   endtask

   ////////////////////
   // Unibus responder
   ////////////////////
   initial
   begin : responder
      int   waited;
      logic acked;
      uniACKI  = 1'b0;
      uniDATAI = '0;
      waited   = 0;
      acked    = 1'b0;
      forever
      begin
         @(posedge clk);
         uniACKI <= 1'b0;
         if (uniREQO !== 1'b1)
         begin
            waited = 0;
            acked  = 1'b0;
         end
         else if (!acked && ackEnable)
         begin
            if (waited == ackDelay)
            begin
               uniACKI  <= 1'b1;
               uniDATAI <= respData;
               acked    = 1'b1;
            end
            waited++;
         end
      end
   end

   // Run length limit and bound checker watch
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT)
         stopRun($sformatf("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT));
      if (u_uba.u_ubaAssert.failCount != 0)
         stopRun("A protocol assertion on the DUT failed");
   end

   ////////////////////
   // Main sequence
   ////////////////////
   initial
   begin
      void'($urandom(32'hd0aa2431));
      rst       <= 1'b1;
      busREQI   = 1'b0;
      busADDRI  = '0;
      busDATAI  = '0;
      ackEnable = 1'b0;
      ackDelay  = 0;
      respData  = '0;
      repeat (16)
         @(posedge clk);
      rst <= 1'b0;

      statusAccess("reset status", 1'b0, '0, statusWord(1'b0, 1'b0));

      // Interrupt enable on and read back
      statusAccess("status write ie", 1'b1, statusWord(1'b0, 1'b1), '0);
      statusAccess("status read ie", 1'b0, '0, statusWord(1'b0, 1'b1));
      checkValue("intrO before timeout", 0, intrO);

      for (int i = 0; i < 8; i++)
      begin
         if (i % 2 == 0)
            uniTransfer("unibus write", 1'b1, $urandom % (MAX_DELAY + 1));
         else
            uniTransfer("unibus read", 1'b0, $urandom % (MAX_DELAY + 1));
      end

      // Nobody answers this one
      ackEnable = 1'b0;
      issueRequest(addrWord(1'b1, 1'b0, 1'b1, `UBA_DEVICE, 18'o000200), '0);
      waitAck();
      checkValue("timeout busDATAO", '0, ackData);
      checkValue("timeout uniREQO length", `UBA_TIMEOUT, reqCycles);
      checkValue("timeout ack latency", `UBA_TIMEOUT + 2, ackLatency);
      statusAccess("status read tmo", 1'b0, '0, statusWord(1'b1, 1'b1));
      checkValue("intrO after timeout", 1, intrO);

      // Write one to TMO and the interrupt drops a cycle later
      statusAccess("status clear tmo", 1'b1, statusWord(1'b1, 1'b1), '0);
      @(posedge clk);
      @(negedge clk);
      checkValue("intrO after clear", 0, intrO);
      statusAccess("status read cleared", 1'b0, '0, statusWord(1'b0, 1'b1));

      issueRequest(addrWord(1'b1, 1'b0, 1'b1, 4'd5, 18'o000100), '0);
      watchIdle("other device");
      issueRequest(addrWord(1'b0, 1'b1, 1'b0, `UBA_DEVICE, 18'o000100), '1);
      watchIdle("memory request");
      issueRequest(addrWord(1'b1, 1'b1, 1'b1, `UBA_DEVICE, 18'o000100), '1);
      watchIdle("both flags");

      if (u_uba.u_ubaAssert.failCount != 0)
         stopRun("A protocol assertion on the DUT failed");
      else
      begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/ubaPkg.sv
hw/ubaTimeout.sv
hw/ubaDecode.sv
hw/ubaExecute.sv
hw/ubaResult.sv
hw/uba.sv
sim/uba_assert.sv
sim/ubaTb.sv

// ==== Bender.yml ====
package:
  name: uba

export_include_dirs:
  - hw

sources:
  - hw/ubaPkg.sv
  - hw/ubaTimeout.sv
  - hw/ubaDecode.sv
  - hw/ubaExecute.sv
  - hw/ubaResult.sv
  - hw/uba.sv
  - target: simulation
    files:
      - sim/uba_assert.sv
      - sim/ubaTb.sv
